//--- rtl/adc_stream_pkg.sv
// sample widths and types for the adc data path, imported by the pipeline, top and testbench
`default_nettype none

package adc_stream_pkg;

  //////////////////////////////////////////////////////////////////////
  // converter geometry
  //////////////////////////////////////////////////////////////////////

  localparam int ADC_DW   = 14;  // bits per sample
  localparam int N_ADC_CH = 4;   // channels on the front end

  //////////////////////////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////////////////////////

  // raw pin word as the converter sends it
  // offset binary with the magnitude bits inverted (negative slope)
  typedef logic [ADC_DW-1:0] adc_raw_t;

  // converted sample, two's complement
  typedef logic signed [ADC_DW-1:0] adc_sample_t;

endpackage

`default_nettype wire

//--- rtl/reset_ctrl_pkg.sv
// reset sequencer states and default hold and pdm constants, imported by the control modules
`default_nettype none

package reset_ctrl_pkg;

  // adc domain reset sequencer states
  typedef enum logic [1:0] {
    ST_WAIT_SETUP = 2'd0,  // converter setup still running
    ST_WAIT_LOCK  = 2'd1,  // setup done, synthesizer not locked yet
    ST_HOLD       = 2'd2,  // locked, reset still held
    ST_RUN        = 2'd3   // reset released
  } rst_state_e;

  localparam int HOLD_CYCLES_DEF = 64;  // post lock reset hold

  //////////////////////////////////////////////////////////////////////
  // slow analog outputs
  //////////////////////////////////////////////////////////////////////

  localparam int PDM_DW    = 8;    // level width
  localparam int PDM_RANGE = 255;  // full scale density
  localparam int N_PDM_CH  = 4;    // number of outputs

endpackage

`default_nettype wire

//--- rtl/lock_hold_timer.sv
// counter that times the reset hold after lock, enabled and cleared by the sequencer
`timescale 1ns/1ps
`default_nettype none

module lock_hold_timer #(
  parameter int HOLD_CYCLES = 64  // cycles of hold, 2 or more
)(
  input  wire  adc_clk_01,
  input  wire  rst_i,
  input  wire  hold_run_i,   // count while high, clear while low
  output logic hold_done_o   // single pulse at the last hold cycle
);

  // one extra code so the counter parks past the terminal value
  localparam int                 CW      = $clog2(HOLD_CYCLES + 1);
  localparam logic [CW-1:0]      CNT_END = CW'(HOLD_CYCLES - 1);
  localparam logic [CW-1:0]      CNT_MAX = CW'(HOLD_CYCLES);

  logic [CW-1:0] cnt_q;

  always_ff @(posedge adc_clk_01) begin
    if (rst_i || !hold_run_i) begin
      cnt_q <= '0;
    end else if (cnt_q != CNT_MAX) begin
      cnt_q <= cnt_q + 1'b1;  // stops at max, no wrap
    end
  end

  // high in the cycle the count sits on the last hold value
  assign hold_done_o = hold_run_i && (cnt_q == CNT_END);

endmodule

`default_nettype wire

//--- rtl/adc_reset_sequencer.sv
// fsm that turns converter setup and synthesizer lock status into the adc domain reset
`timescale 1ns/1ps
`default_nettype none

module adc_reset_sequencer (
  input  wire  adc_clk_01,
  input  wire  rst_i,
  input  wire  spi_done_i,    // async status
  input  wire  pll_locked_i,  // async status
  input  wire  hold_done_i,   // from hold timer
  output logic hold_run_o,    // timer enable
  output logic adc_rst_o      // active high and released only in run
);

  import reset_ctrl_pkg::*;

  logic       spi_meta_q;  // first sync flop
  logic       spi_sync_q;  // second sync flop feeds the fsm
  logic       lock_q;      // lock status in one register
  rst_state_e state_q;
  rst_state_e state_nxt;

  //////////////////////////////////////////////////////////////////////
  // status capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      spi_meta_q <= 1'b0;
      spi_sync_q <= 1'b0;
      lock_q     <= 1'b0;
    end else begin
      spi_meta_q <= spi_done_i;
      spi_sync_q <= spi_meta_q;
      lock_q     <= pll_locked_i;  // single register stage
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state_q;  // hold by default
    unique case (state_q)
      ST_WAIT_SETUP: begin
        if (spi_sync_q) state_nxt = ST_WAIT_LOCK;
      end
      ST_WAIT_LOCK: begin
        if (!spi_sync_q)  state_nxt = ST_WAIT_SETUP;
        else if (lock_q)  state_nxt = ST_HOLD;
      end
      ST_HOLD: begin
        if (!spi_sync_q)       state_nxt = ST_WAIT_SETUP;
        else if (!lock_q)      state_nxt = ST_WAIT_LOCK;  // lost lock mid hold
        else if (hold_done_i)  state_nxt = ST_RUN;
      end
      ST_RUN: begin
        if (!spi_sync_q)   state_nxt = ST_WAIT_SETUP;  // converter reconfigured
        else if (!lock_q)  state_nxt = ST_WAIT_LOCK;
      end
      default: state_nxt = ST_WAIT_SETUP;
    endcase
  end

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) state_q <= ST_WAIT_SETUP;
    else       state_q <= state_nxt;
  end

  // outputs decoded straight from the state register
  assign hold_run_o = (state_q == ST_HOLD);
  assign adc_rst_o  = (state_q != ST_RUN);

endmodule

`default_nettype wire

//--- rtl/adc_sample_pipe.sv
// three stage capture and offset binary to two's complement conversion for all adc channels
`timescale 1ns/1ps
`default_nettype none

module adc_sample_pipe #(
  parameter int N_CH = adc_stream_pkg::N_ADC_CH
)(
  input  wire                                        adc_clk_01,
  input  wire                                        adc_rst_i,    // adc domain reset
  input  wire  adc_stream_pkg::adc_raw_t [N_CH-1:0]  adc_raw_i,    // straight from the pins
  output adc_stream_pkg::adc_sample_t    [N_CH-1:0]  adc_dat_o,
  output logic                                       adc_valid_o
);

  import adc_stream_pkg::*;

  adc_raw_t    [N_CH-1:0] raw_q;   // stage 1
  adc_sample_t [N_CH-1:0] conv_q;  // stage 2
  logic        [2:0]      vld_q;   // follows the three data stages

  //////////////////////////////////////////////////////////////////////
  // data stages, no reset on payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    for (int ch = 0; ch < N_CH; ch++) begin
      raw_q[ch]     <= adc_raw_i[ch];  // reg to reg point for pin timing
      // sign bit kept, magnitude flipped back to positive slope
      conv_q[ch]    <= adc_sample_t'({raw_q[ch][ADC_DW-1], ~raw_q[ch][ADC_DW-2:0]});
      adc_dat_o[ch] <= conv_q[ch];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // valid flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (adc_rst_i) vld_q <= '0;
    else           vld_q <= {vld_q[1:0], 1'b1};  // fills once reset is gone
  end

  assign adc_valid_o = vld_q[2];

endmodule

`default_nettype wire

//--- rtl/pdm_bank.sv
// accumulator based pulse density modulators that drive the slow analog outputs
`timescale 1ns/1ps
`default_nettype none

module pdm_bank #(
  parameter int N_CH = reset_ctrl_pkg::N_PDM_CH
)(
  input  wire                                         adc_clk_01,
  input  wire                                         adc_rst_i,  // adc domain reset
  input  wire  [N_CH-1:0][reset_ctrl_pkg::PDM_DW-1:0] pdm_cfg_i,  // level per channel
  output logic [N_CH-1:0]                             pdm_o       // one bit outputs
);

  import reset_ctrl_pkg::*;

  // one spare bit holds acc plus level without overflow
  localparam int                SUM_W   = PDM_DW + 1;
  localparam logic [SUM_W-1:0]  RANGE_W = SUM_W'(PDM_RANGE);

  logic [SUM_W-1:0] acc_q [N_CH];  // always below full scale
  logic [SUM_W-1:0] sum   [N_CH];

  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      sum[ch] = acc_q[ch] + {1'b0, pdm_cfg_i[ch]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // accumulate and emit
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (adc_rst_i) begin
      for (int ch = 0; ch < N_CH; ch++) begin
        acc_q[ch] <= '0;
      end
      pdm_o <= '0;
    end else begin
      for (int ch = 0; ch < N_CH; ch++) begin
        if (sum[ch] >= RANGE_W) begin
          acc_q[ch] <= sum[ch] - RANGE_W;  // carry out of the full scale
          pdm_o[ch] <= 1'b1;
        end else begin
          acc_q[ch] <= sum[ch];
          pdm_o[ch] <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/adc_frontend_top.sv
// acquisition front end top, wires the reset sequencer, hold timer, sample pipe and pdm bank
`timescale 1ns/1ps
`default_nettype none

module adc_frontend_top #(
  parameter int HOLD_CYCLES = reset_ctrl_pkg::HOLD_CYCLES_DEF  // post lock hold, 2 or more
)(
  input  wire                                            adc_clk_01,
  input  wire                                            rst_i,        // chip reset
  input  wire                                            spi_done_i,   // async, adc setup done
  input  wire                                            pll_locked_i, // async, synth lock
  input  wire  adc_stream_pkg::adc_raw_t [adc_stream_pkg::N_ADC_CH-1:0] adc_raw_i,
  input  wire  [reset_ctrl_pkg::N_PDM_CH-1:0][reset_ctrl_pkg::PDM_DW-1:0] pdm_cfg_i,
  output adc_stream_pkg::adc_sample_t [adc_stream_pkg::N_ADC_CH-1:0] adc_dat_o,
  output logic                                           adc_valid_o,
  output logic                                           adc_rst_o,    // adc domain reset
  output wire  [reset_ctrl_pkg::N_PDM_CH-1:0]            pdm_o
);

  import adc_stream_pkg::*;
  import reset_ctrl_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // reset sequencing
  //////////////////////////////////////////////////////////////////////

  logic hold_run;   // sequencer asks timer to count
  logic hold_done;  // timer reached the end of the hold

  adc_reset_sequencer i_seq (
    .adc_clk_01   (adc_clk_01  ),
    .rst_i        (rst_i       ),
    .spi_done_i   (spi_done_i  ),
    .pll_locked_i (pll_locked_i),
    .hold_done_i  (hold_done   ),
    .hold_run_o   (hold_run    ),
    .adc_rst_o    (adc_rst_o   )   // also feeds the data modules below
  );

  lock_hold_timer #(
    .HOLD_CYCLES (HOLD_CYCLES)
  ) i_hold (
    .adc_clk_01  (adc_clk_01),
    .rst_i       (rst_i     ),
    .hold_run_i  (hold_run  ),
    .hold_done_o (hold_done )
  );

  //////////////////////////////////////////////////////////////////////
  // data path on the adc domain reset
  //////////////////////////////////////////////////////////////////////

  adc_sample_pipe #(
    .N_CH (N_ADC_CH)
  ) i_pipe (
    .adc_clk_01  (adc_clk_01 ),
    .adc_rst_i   (adc_rst_o  ),
    .adc_raw_i   (adc_raw_i  ),
    .adc_dat_o   (adc_dat_o  ),
    .adc_valid_o (adc_valid_o)
  );

  pdm_bank #(
    .N_CH (N_PDM_CH)
  ) i_pdm (
    .adc_clk_01 (adc_clk_01),
    .adc_rst_i  (adc_rst_o ),
    .pdm_cfg_i  (pdm_cfg_i ),
    .pdm_o      (pdm_o     )
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// free running clock source for the testbench, half period derived from the period parameter
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100  // full period
)(
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;  // first rising edge at half a period
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- testbench/tb_adc_frontend.sv
// testbench for the acquisition front end, drives status, samples and pdm levels, checks by assertions
`timescale 1ns/1ps
`default_nettype none

module tb_adc_frontend;

  import adc_stream_pkg::*;
  import reset_ctrl_pkg::*;

  localparam int       HOLD     = 16;             // short hold for the run
  localparam int       SEED     = 32'h57f9;
  localparam int       PDM_WIN  = PDM_RANGE + 1;  // start cycle plus counted cycles
  localparam adc_raw_t MAG_MASK = 14'h1fff;       // lower 13 bits

  logic                            adc_clk_01;
  logic                            rst_i;
  logic                            spi_done_i;
  logic                            pll_locked_i;
  adc_raw_t    [N_ADC_CH-1:0]      adc_raw_i;
  logic [N_PDM_CH-1:0][PDM_DW-1:0] pdm_cfg_i;
  adc_sample_t [N_ADC_CH-1:0]      adc_dat_o;
  logic                            adc_valid_o;
  logic                            adc_rst_o;
  wire  [N_PDM_CH-1:0]             pdm_o;

  logic                    chk_en;                // assertions armed
  adc_raw_t [N_ADC_CH-1:0] raw_hist [3];          // reference delay line
  int                      pdm_age;               // edges since adc_rst_o fell
  logic [PDM_DW:0]         ones_cnt [N_PDM_CH];   // ones seen per pdm channel

  tb_clock_gen #(
    .PERIOD_NS (100)
  ) i_clk (
    .clk_o (adc_clk_01)
  );

  adc_frontend_top #(
    .HOLD_CYCLES (HOLD)
  ) uut (
    .adc_clk_01   (adc_clk_01  ),
    .rst_i        (rst_i       ),
    .spi_done_i   (spi_done_i  ),
    .pll_locked_i (pll_locked_i),
    .adc_raw_i    (adc_raw_i   ),
    .pdm_cfg_i    (pdm_cfg_i   ),
    .adc_dat_o    (adc_dat_o   ),
    .adc_valid_o  (adc_valid_o ),
    .adc_rst_o    (adc_rst_o   ),
    .pdm_o        (pdm_o       )
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // sign bit passes, magnitude bits flip back
  function automatic adc_sample_t expected_sample(input adc_raw_t raw);
    return adc_sample_t'(raw ^ MAG_MASK);
  endfunction

  always @(posedge adc_clk_01) begin
    for (int ch = 0; ch < N_ADC_CH; ch++) begin
      adc_raw_i[ch] <= 14'($urandom);  // new word per channel every cycle
    end
  end

  always @(posedge adc_clk_01) begin
    raw_hist[0] <= adc_raw_i;  // value the dut captures on this edge
    raw_hist[1] <= raw_hist[0];
    raw_hist[2] <= raw_hist[1];
  end

  // ones counter over the first full pdm period after release
  always @(posedge adc_clk_01) begin
    if (rst_i || adc_rst_o !== 1'b0) begin
      pdm_age <= 0;
      for (int ch = 0; ch < N_PDM_CH; ch++) begin
        ones_cnt[ch] <= '0;
      end
    end else if (pdm_age < PDM_WIN) begin
      pdm_age <= pdm_age + 1;
      if (pdm_age > 0) begin  // first sample still comes from reset
        for (int ch = 0; ch < N_PDM_CH; ch++) begin
          ones_cnt[ch] <= ones_cnt[ch] + {{PDM_DW{1'b0}}, pdm_o[ch]};
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stop_failed();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string what);
    $display("ERR %0t: %s", $time, what);
    stop_failed();
  endtask

  task automatic timeout_error(input string what);
    $display("timed out: %s", what);
    stop_failed();
  endtask

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  // released only with lock two samples back and setup three back
  a_rst_gate: assert property (@(posedge adc_clk_01) disable iff (!chk_en)
      !adc_rst_o |-> $past(pll_locked_i, 2) && $past(spi_done_i, 3))
    else value_error("adc_rst_o low without lock and setup done");

  // release lands HOLD+2 edges after the edge that drove lock high
  a_rst_release: assert property (@(posedge adc_clk_01) disable iff (!chk_en)
      $fell(adc_rst_o) |-> $past(pll_locked_i, HOLD + 2) && !$past(pll_locked_i, HOLD + 3))
    else value_error("adc_rst_o fell at the wrong edge after lock");

  // valid needs three clean reset samples
  a_valid_track: assert property (@(posedge adc_clk_01) disable iff (!chk_en)
      adc_valid_o == (!$past(adc_rst_o, 1) && !$past(adc_rst_o, 2) && !$past(adc_rst_o, 3)))
    else value_error($sformatf("adc_valid_o = %b does not follow adc_rst_o",
                               $sampled(adc_valid_o)));

  a_pdm_idle: assert property (@(posedge adc_clk_01) disable iff (!chk_en)
      $past(adc_rst_o) |-> pdm_o == '0)
    else value_error($sformatf("pdm_o = %b while in reset", $sampled(pdm_o)));

  for (genvar ch = 0; ch < N_ADC_CH; ch++) begin : g_dat_chk
    a_dat: assert property (@(posedge adc_clk_01) disable iff (!chk_en)
        adc_valid_o |-> adc_dat_o[ch] == expected_sample(raw_hist[2][ch]))
      else value_error($sformatf("adc_dat_o[%0d] = %h, expected %h", ch,
                                 $sampled(adc_dat_o[ch]),
                                 expected_sample($sampled(raw_hist[2][ch]))));
  end

  for (genvar ch = 0; ch < N_PDM_CH; ch++) begin : g_pdm_chk
    a_pdm_count: assert property (@(posedge adc_clk_01) disable iff (!chk_en)
        pdm_age == PDM_WIN |-> ones_cnt[ch] == {1'b0, pdm_cfg_i[ch]})
      else value_error($sformatf("pdm_o[%0d] gave %0d ones, level %0d", ch,
                                 $sampled(ones_cnt[ch]), $sampled(pdm_cfg_i[ch])));
  end

  //////////////////////////////////////////////////////////////////////
  // bounded waits
  //////////////////////////////////////////////////////////////////////

  task automatic wait_adc_rst(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (adc_rst_o !== level && n < limit) begin
      @(posedge adc_clk_01);
      n++;
    end
    if (adc_rst_o !== level) timeout_error(what);
  endtask

  task automatic wait_valid(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (adc_valid_o !== level && n < limit) begin
      @(posedge adc_clk_01);
      n++;
    end
    if (adc_valid_o !== level) timeout_error(what);
  endtask

  task automatic wait_pdm_window(input int limit, input string what);
    int n;
    n = 0;
    while (pdm_age != PDM_WIN && n < limit) begin
      @(posedge adc_clk_01);
      n++;
    end
    if (pdm_age != PDM_WIN) timeout_error(what);
  endtask

  // lock comes up, stream runs through one full pdm period
  task automatic lock_and_run();
    @(posedge adc_clk_01);
    pll_locked_i <= 1'b1;
    wait_adc_rst(1'b0, HOLD + 8, "adc_rst_o never fell, sequencer did not reach ST_RUN");
    wait_valid(1'b1, 8, "adc_valid_o never rose after adc_rst_o fell");
    wait_pdm_window(PDM_RANGE + 8, "pdm count window never completed");
    @(posedge adc_clk_01);
  endtask

  task automatic drop_lock();
    @(posedge adc_clk_01);
    pll_locked_i <= 1'b0;
    wait_adc_rst(1'b1, 4, "adc_rst_o stayed low after lock was lost");
    wait_valid(1'b0, 4, "adc_valid_o stayed high after lock was lost");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_i        <= 1'b1;
    spi_done_i   <= 1'b0;
    pll_locked_i <= 1'b0;
    chk_en       <= 1'b0;
    pdm_cfg_i[0] <= 8'd0;    // never fires
    pdm_cfg_i[1] <= 8'd255;  // fires every cycle
    pdm_cfg_i[2] <= 8'($urandom);
    pdm_cfg_i[3] <= 8'($urandom);
    for (int ch = 0; ch < N_ADC_CH; ch++) begin
      adc_raw_i[ch] <= 14'($urandom);
    end

    repeat (3) @(posedge adc_clk_01);
    rst_i <= 1'b0;
    repeat (4) @(posedge adc_clk_01);  // let the past values settle
    chk_en <= 1'b1;

    repeat (20) @(posedge adc_clk_01);  // nothing up, everything quiet
    pll_locked_i <= 1'b1;               // lock alone must not release
    repeat (12) @(posedge adc_clk_01);
    pll_locked_i <= 1'b0;
    repeat (4) @(posedge adc_clk_01);
    spi_done_i <= 1'b1;                 // setup done, waiting in ST_WAIT_LOCK
    repeat (12) @(posedge adc_clk_01);

    lock_and_run();
    drop_lock();
    repeat (10) @(posedge adc_clk_01);
    lock_and_run();

    // converter reconfigured while running
    @(posedge adc_clk_01);
    spi_done_i <= 1'b0;
    wait_adc_rst(1'b1, 6, "adc_rst_o stayed low after setup done was withdrawn");
    wait_valid(1'b0, 4, "adc_valid_o stayed high after setup done was withdrawn");
    repeat (5) @(posedge adc_clk_01);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
rtl/adc_stream_pkg.sv
rtl/reset_ctrl_pkg.sv
rtl/lock_hold_timer.sv
rtl/adc_reset_sequencer.sv
rtl/adc_sample_pipe.sv
rtl/pdm_bank.sv
rtl/adc_frontend_top.sv
testbench/tb_clock_gen.sv
testbench/tb_adc_frontend.sv

//--- Makefile
# Verilator build and run of the acquisition front end testbench

VERILATOR  ?= verilator
TOP        := tb_adc_frontend
LINT_TOP   := adc_frontend_top
FILELIST   := sim.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the binary carries pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
